// ==== bench/uart_checker.sv ====
/*
 * checker, compares acknowledged reads, line levels and transmitted frames
 */

`timescale 1ns/100ps

module uart_checker #(
   parameter int BIT_CYC = 8,
   parameter int DATA_W  = uart_pkg::DATA_W
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              ack0_i,
   input  logic [DATA_W-1:0] rdata0_i,
   input  logic [DATA_W-1:0] exp0_i,
   input  logic              cmp0_i,
   input  logic              ack1_i,
   input  logic [DATA_W-1:0] rdata1_i,
   input  logic [DATA_W-1:0] exp1_i,
   input  logic              cmp1_i,
   input  logic              pair_i,
   input  logic              line_chk_i,
   input  logic              exp_txd_i,
   input  logic              exp_rts_i,
   input  logic              txd_i,
   input  logic              rts_i,
   input  logic              frame_en_i,
   input  logic [7:0]        exp_byte_i,
   output int                checks_o,
   output int                errors_o
);

   int   n_checks = 0;
   int   n_errors = 0;
   logic seen0    = 1'b0;  // host 0 acked in the current paired access

   assign checks_o = n_checks;
   assign errors_o = n_errors;

   task automatic compare(input logic ok, input string msg);
      n_checks++;
      if (!ok) begin
         n_errors++;
         $display("Mismatch at %0t: %s", $time, msg);
      end
   endtask

   //////////////////////////////
   // bus side
   //////////////////////////////
   always @(negedge clk_i) begin
      if (rst_n_i) begin
         if (ack0_i && cmp0_i) begin
            compare(rdata0_i === exp0_i,
                    $sformatf("host 0 read %04h, expected %04h", rdata0_i, exp0_i));
         end
         if (ack1_i && cmp1_i) begin
            compare(rdata1_i === exp1_i,
                    $sformatf("host 1 read %04h, expected %04h", rdata1_i, exp1_i));
         end
         if (line_chk_i) begin
            compare(txd_i === exp_txd_i && rts_i === exp_rts_i,
                    $sformatf("txd %b rts %b, expected txd %b rts %b",
                              txd_i, rts_i, exp_txd_i, exp_rts_i));
         end
         if (!pair_i) begin
            seen0 = 1'b0;
         end else begin
            if (ack1_i) begin
               n_checks++;
               if (!seen0) begin  // priority broken
                  n_errors++;
                  $display("Error at %0t: host 1 was served before host 0", $time);
               end
            end
            if (ack0_i) begin
               seen0 = 1'b1;
            end
         end
      end
   end

   //////////////////////////////
   // serial side
   //////////////////////////////
   initial begin : frame_decode
      logic [9:0] bits;
      logic       chk;
      logic [7:0] expb;
      forever begin
         @(negedge txd_i);  // start bit edge
         chk  = frame_en_i;
         expb = exp_byte_i;
         repeat (BIT_CYC / 2) @(negedge clk_i);
         bits[0] = txd_i;
         for (int i = 1; i < 10; i++) begin
            repeat (BIT_CYC) @(negedge clk_i);
            bits[i] = txd_i;
         end
         if (chk) begin
            compare(bits[0] === 1'b0, "start bit of a frame is not low");
            compare(bits[9] === 1'b1, "stop bit of a frame is not high");
            compare(bits[8:1] === expb,
                    $sformatf("frame byte %02h, expected %02h", bits[8:1], expb));
         end
      end
   end

endmodule

// ==== bench/uart_tb.sv ====
/*
 * testbench top, clock and reset, register step table, serial loopback, watchdog
 */

`timescale 1ns/100ps

module uart_tb;

   import uart_pkg::*;

   localparam int DIV_VAL  = 8;  // bit duration programmed into DIV
   localparam int MAX_ROWS = 64;

   // step kinds
   localparam int A_WR    = 0;
   localparam int A_RD    = 1;
   localparam int A_TX    = 2;  // txdata write, frame checked
   localparam int A_ABORT = 3;  // txdata write, frame cut by soft reset
   localparam int A_PAIR  = 4;  // this row on host 0, next row on host 1
   localparam int A_IDLE  = 5;
   localparam int A_CTS   = 6;
   localparam int A_LINE  = 7;  // data[0] txd, data[1] rts
   localparam int W_NONE  = 0;
   localparam int W_TX    = 1;
   localparam int W_RX    = 2;
   localparam int HR      = 2;  // random host

   logic              clk;
   logic              rst_n;
   logic              req0, we0, cmp0, ack0;
   logic              req1, we1, cmp1, ack1;
   logic [ADDR_W-1:0] addr0, addr1;
   logic [DATA_W-1:0] wdata0, wdata1, exp0, exp1, rdata0, rdata1;
   logic              cts, txd, rts;
   logic              pair, line_chk, exp_txd, exp_rts, frame_en;
   logic [7:0]        exp_byte;
   logic [DATA_W-1:0] last_rdata;
   int                n_checks, n_errors;

   int                act_col[MAX_ROWS];
   int                host_col[MAX_ROWS];
   int                wait_col[MAX_ROWS];
   logic [ADDR_W-1:0] addr_col[MAX_ROWS];
   logic [DATA_W-1:0] data_col[MAX_ROWS];
   logic [DATA_W-1:0] exp_col[MAX_ROWS];
   int                n_rows      = 0;
   logic              table_ready = 1'b0;

   uart_top #(.DIV_W(DIV_W), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_uart_top (
      .clk_i(clk), .rst_n_i(rst_n),
      .host0_req_i(req0), .host0_we_i(we0), .host0_addr_i(addr0),
      .host0_wdata_i(wdata0), .host0_ack_o(ack0), .host0_rdata_o(rdata0),
      .host1_req_i(req1), .host1_we_i(we1), .host1_addr_i(addr1),
      .host1_wdata_i(wdata1), .host1_ack_o(ack1), .host1_rdata_o(rdata1),
      .rxd_i(txd),  // loopback
      .cts_i(cts), .txd_o(txd), .rts_o(rts)
   );

   uart_checker #(.BIT_CYC(DIV_VAL), .DATA_W(DATA_W)) i_uart_checker (
      .clk_i(clk), .rst_n_i(rst_n),
      .ack0_i(ack0), .rdata0_i(rdata0), .exp0_i(exp0), .cmp0_i(cmp0),
      .ack1_i(ack1), .rdata1_i(rdata1), .exp1_i(exp1), .cmp1_i(cmp1),
      .pair_i(pair), .line_chk_i(line_chk), .exp_txd_i(exp_txd), .exp_rts_i(exp_rts),
      .txd_i(txd), .rts_i(rts), .frame_en_i(frame_en), .exp_byte_i(exp_byte),
      .checks_o(n_checks), .errors_o(n_errors)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic add_row(input int act, input int host, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp,
                          input int wt);
      act_col[n_rows]  = act;
      host_col[n_rows] = (host == HR) ? int'($urandom % 2) : host;
      addr_col[n_rows] = addr;
      data_col[n_rows] = data;
      exp_col[n_rows]  = exp;
      wait_col[n_rows] = wt;
      n_rows++;
   endtask

   task automatic build_table();
      logic [7:0] b;
      add_row(A_LINE, 0, CSR_DIV, 16'h0001, '0, W_NONE);  // txd high, rts low
      add_row(A_RD, 0, CSR_STATUS, '0, 16'h0000, W_NONE);
      add_row(A_RD, 1, CSR_CTRL, '0, 16'h0000, W_NONE);
      add_row(A_WR, HR, CSR_DIV, DATA_W'(DIV_VAL), '0, W_NONE);
      add_row(A_WR, HR, CSR_CTRL, 16'h0003, '0, W_NONE);
      add_row(A_PAIR, 0, CSR_DIV, '0, DATA_W'(DIV_VAL), W_NONE);
      add_row(A_RD, 1, CSR_CTRL, '0, 16'h0003, W_NONE);
      add_row(A_IDLE, 0, CSR_DIV, 16'd20, '0, W_NONE);  // rx settles on the idle line
      add_row(A_LINE, 0, CSR_DIV, 16'h0003, '0, W_NONE);
      for (int k = 0; k < 3; k++) begin
         b = (k == 2) ? 8'hA5 : 8'($urandom);
         add_row(A_TX, HR, CSR_TXDATA, {8'h00, b}, '0, W_NONE);
         add_row(A_RD, HR, CSR_RXDATA, '0, {8'h00, b}, W_RX);
         add_row(A_RD, HR, CSR_STATUS, '0, 16'h0001, W_TX);  // rx_ready cleared
      end
      // held by cts
      b = 8'($urandom);
      add_row(A_CTS, 0, CSR_DIV, 16'h0000, '0, W_NONE);
      add_row(A_IDLE, 0, CSR_DIV, 16'd4, '0, W_NONE);
      add_row(A_TX, HR, CSR_TXDATA, {8'h00, b}, '0, W_NONE);
      add_row(A_IDLE, 0, CSR_DIV, 16'd30, '0, W_NONE);
      add_row(A_LINE, 0, CSR_DIV, 16'h0003, '0, W_NONE);
      add_row(A_RD, HR, CSR_STATUS, '0, 16'h0000, W_NONE);
      add_row(A_CTS, 0, CSR_DIV, 16'h0001, '0, W_NONE);
      add_row(A_RD, HR, CSR_RXDATA, '0, {8'h00, b}, W_RX);
      add_row(A_RD, HR, CSR_STATUS, '0, 16'h0001, W_TX);
      // soft reset in mid frame, with a received byte left unread
      add_row(A_TX, HR, CSR_TXDATA, {8'h00, 8'($urandom)}, '0, W_NONE);
      add_row(A_IDLE, 0, CSR_DIV, 16'd1, '0, W_RX);
      add_row(A_ABORT, HR, CSR_TXDATA, {8'h00, 8'($urandom)}, '0, W_TX);
      add_row(A_IDLE, 0, CSR_DIV, 16'd30, '0, W_NONE);
      add_row(A_WR, HR, CSR_CTRL, 16'h0007, '0, W_NONE);
      add_row(A_IDLE, 0, CSR_DIV, 16'd2, '0, W_NONE);
      add_row(A_LINE, 0, CSR_DIV, 16'h0003, '0, W_NONE);
      add_row(A_RD, HR, CSR_STATUS, '0, 16'h0001, W_NONE);
      add_row(A_RD, HR, CSR_CTRL, '0, 16'h0003, W_NONE);
   endtask

   task automatic drive_host(input int h, input logic req, input logic we,
                             input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [DATA_W-1:0] exp, input logic cmp);
      if (h == 0) begin
         req0   <= req;
         we0    <= we;
         addr0  <= addr;
         wdata0 <= wdata;
         exp0   <= exp;
         cmp0   <= cmp;
      end else begin
         req1   <= req;
         we1    <= we;
         addr1  <= addr;
         wdata1 <= wdata;
         exp1   <= exp;
         cmp1   <= cmp;
      end
   endtask

   // one access, req held until ack
   task automatic run_access(input int h, input logic we, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp,
                             input logic cmp);
      logic acked;
      acked = 1'b0;
      @(posedge clk);
      drive_host(h, 1'b1, we, addr, wdata, exp, cmp);
      while (!acked) begin
         @(negedge clk);
         acked = (h == 0) ? ack0 : ack1;
      end
      last_rdata = (h == 0) ? rdata0 : rdata1;
      @(posedge clk);
      drive_host(h, 1'b0, 1'b0, '0, '0, '0, 1'b0);
   endtask

   task automatic run_pair(input int r);
      logic a0, a1, got0, got1;
      got0 = 1'b0;
      got1 = 1'b0;
      @(posedge clk);
      drive_host(0, 1'b1, 1'b0, addr_col[r], '0, exp_col[r], 1'b1);
      drive_host(1, 1'b1, 1'b0, addr_col[r+1], '0, exp_col[r+1], 1'b1);
      pair <= 1'b1;
      while (!(got0 && got1)) begin
         @(negedge clk);
         a0 = ack0;
         a1 = ack1;
         @(posedge clk);
         if (a0) drive_host(0, 1'b0, 1'b0, '0, '0, '0, 1'b0);
         if (a1) drive_host(1, 1'b0, 1'b0, '0, '0, '0, 1'b0);
         got0 = got0 | a0;
         got1 = got1 | a1;
      end
      pair <= 1'b0;
   endtask

   task automatic poll_status(input int h, input int bit_idx);
      do begin
         run_access(h, 1'b0, CSR_STATUS, '0, '0, 1'b0);
      end while (!last_rdata[bit_idx]);
   endtask

   task automatic print_counts();
      $display("checks: %0d, errors: %0d", n_checks, n_errors);
   endtask

   //////////////////////////////
   // stimulus
   //////////////////////////////
   initial begin : stimulus
      int r;
      int seed_val;
      seed_val = $urandom(46);
      rst_n = 1'b0;
      {req0, we0, cmp0, req1, we1, cmp1} = '0;
      {addr0, addr1, wdata0, wdata1, exp0, exp1} = '0;
      cts = 1'b1;
      {pair, line_chk, exp_txd, exp_rts, frame_en} = '0;
      exp_byte = 8'h00;
      build_table();
      table_ready = 1'b1;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      r = 0;
      while (r < n_rows) begin
         if (wait_col[r] == W_TX) poll_status(host_col[r], 0);
         if (wait_col[r] == W_RX) poll_status(host_col[r], 1);
         case (act_col[r])
            A_WR: run_access(host_col[r], 1'b1, addr_col[r], data_col[r], '0, 1'b0);
            A_RD: run_access(host_col[r], 1'b0, addr_col[r], '0, exp_col[r], 1'b1);
            A_TX, A_ABORT: begin
               frame_en <= (act_col[r] == A_TX);
               exp_byte <= data_col[r][7:0];
               run_access(host_col[r], 1'b1, CSR_TXDATA, data_col[r], '0, 1'b0);
            end
            A_PAIR: begin
               run_pair(r);
               r++;  // partner row consumed
            end
            A_IDLE: repeat (data_col[r]) @(posedge clk);
            A_CTS: begin
               @(posedge clk);
               cts <= data_col[r][0];
            end
            A_LINE: begin
               @(posedge clk);
               exp_txd  <= data_col[r][0];
               exp_rts  <= data_col[r][1];
               line_chk <= 1'b1;
               @(posedge clk);
               line_chk <= 1'b0;
            end
            default: ;
         endcase
         r++;
      end
      repeat (4) @(posedge clk);
      print_counts();
      if (n_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      wait (table_ready);
      repeat (n_rows * (12 * DIV_VAL + 20)) @(posedge clk);
      $display("Timeout: the step table did not complete in time");
      print_counts();
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== logic/uart_bus_arb.sv ====
/* fixed-priority arbiter, two host ports onto one register bus */

`timescale 1ns/100ps

module uart_bus_arb #(
   parameter int ADDR_W = uart_pkg::ADDR_W,
   parameter int DATA_W = uart_pkg::DATA_W
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              req0_i,
   input  logic              we0_i,
   input  logic [ADDR_W-1:0] addr0_i,
   input  logic [DATA_W-1:0] wdata0_i,
   output logic              ack0_o,
   output logic [DATA_W-1:0] rdata0_o,
   input  logic              req1_i,
   input  logic              we1_i,
   input  logic [ADDR_W-1:0] addr1_i,
   input  logic [DATA_W-1:0] wdata1_i,
   output logic              ack1_o,
   output logic [DATA_W-1:0] rdata1_o,
   output logic              bus_valid_o,
   output logic              bus_we_o,
   output logic [ADDR_W-1:0] bus_addr_o,
   output logic [DATA_W-1:0] bus_wdata_o,
   input  logic [DATA_W-1:0] bus_rdata_i
);

   logic              busy_q;  // access on the bus this cycle
   logic              ack0_q, ack1_q;
   logic              grant0, grant1;
   logic              we_q;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;

   assign grant0 = ~busy_q & req0_i;            // host 0 first
   assign grant1 = ~busy_q & ~req0_i & req1_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
         ack0_q <= 1'b0;
         ack1_q <= 1'b0;
      end else begin
         busy_q <= grant0 | grant1;
         ack0_q <= grant0;
         ack1_q <= grant1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (grant0) begin
         we_q    <= we0_i;
         addr_q  <= addr0_i;
         wdata_q <= wdata0_i;
      end else if (grant1) begin
         we_q    <= we1_i;
         addr_q  <= addr1_i;
         wdata_q <= wdata1_i;
      end
   end

   assign bus_valid_o = busy_q;
   assign bus_we_o    = we_q;
   assign bus_addr_o  = addr_q;
   assign bus_wdata_o = wdata_q;

   // read data only toward the acknowledged host
   assign ack0_o   = ack0_q;
   assign ack1_o   = ack1_q;
   assign rdata0_o = ack0_q ? bus_rdata_i : '0;
   assign rdata1_o = ack1_q ? bus_rdata_i : '0;

endmodule

// ==== logic/uart_csr.sv ====
/*
 * control/status registers, bus decode, engine controls and strobes
 */

`timescale 1ns/100ps

module uart_csr #(
   parameter int ADDR_W = uart_pkg::ADDR_W,
   parameter int DATA_W = uart_pkg::DATA_W,
   parameter int DIV_W  = uart_pkg::DIV_W
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              bus_valid_i,
   input  logic              bus_we_i,
   input  logic [ADDR_W-1:0] bus_addr_i,
   input  logic [DATA_W-1:0] bus_wdata_i,
   output logic [DATA_W-1:0] bus_rdata_o,
   output logic [DIV_W-1:0]  bit_duration_o,
   output logic              tx_en_o,
   output logic              rx_en_o,
   output logic              soft_rst_o,
   output logic              tx_write_o,
   output logic [7:0]        tx_data_o,
   output logic              rx_read_o,
   input  logic              tx_ready_i,
   input  logic              rx_ready_i,
   input  logic [7:0]        rx_data_i
);

   import uart_pkg::*;

   logic [DIV_W-1:0] div_q;
   logic             tx_en_q;
   logic             rx_en_q;
   logic             wr;
   logic             rd;

   assign wr = bus_valid_i & bus_we_i;
   assign rd = bus_valid_i & ~bus_we_i;

   //////////////////////////////
   // stored registers
   //////////////////////////////
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         div_q   <= '0;
         tx_en_q <= 1'b0;
         rx_en_q <= 1'b0;
      end else if (wr) begin
         if (bus_addr_i == CSR_DIV) begin
            div_q <= bus_wdata_i[DIV_W-1:0];
         end
         if (bus_addr_i == CSR_CTRL) begin
            tx_en_q <= bus_wdata_i[0];
            rx_en_q <= bus_wdata_i[1];
         end
      end
   end

   assign bit_duration_o = div_q;
   assign tx_en_o        = tx_en_q;
   assign rx_en_o        = rx_en_q;

   // single-cycle strobes, live in the bus cycle
   assign soft_rst_o = wr & (bus_addr_i == CSR_CTRL) & bus_wdata_i[2];
   assign tx_write_o = wr & (bus_addr_i == CSR_TXDATA);
   assign tx_data_o  = bus_wdata_i[7:0];
   assign rx_read_o  = rd & (bus_addr_i == CSR_RXDATA);

   //////////////////////////////
   // read mux
   //////////////////////////////
   always_comb begin
      bus_rdata_o = '0;
      case (bus_addr_i)
         CSR_DIV:    bus_rdata_o[DIV_W-1:0] = div_q;
         CSR_CTRL:   bus_rdata_o[1:0] = {rx_en_q, tx_en_q};
         CSR_STATUS: bus_rdata_o[1:0] = {rx_ready_i, tx_ready_i};
         CSR_RXDATA: bus_rdata_o[7:0] = rx_data_i;
         default:    bus_rdata_o = '0;  // txdata and holes read zero
      endcase
   end

endmodule

// ==== logic/uart_pkg.sv ====
/*
 * shared widths, register address map and sequencer state encodings
 */

package uart_pkg;

   localparam int DIV_W  = 16;  // bit duration counter
   localparam int ADDR_W = 3;   // register address
   localparam int DATA_W = 16;  // register bus data, holds the divider

   //////////////////////////////
   // register map
   //////////////////////////////
   typedef enum logic [2:0] {
      CSR_DIV    = 3'd0,  // bit duration in clock cycles
      CSR_CTRL   = 3'd1,  // tx_en, rx_en, soft_rst
      CSR_STATUS = 3'd2,  // tx_ready, rx_ready
      CSR_TXDATA = 3'd3,  // write starts a frame
      CSR_RXDATA = 3'd4   // read clears rx_ready
   } csr_addr_e;

   //////////////////////////////
   // sequencer states
   //////////////////////////////
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_LOAD,
      TX_SEND
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_SYNC,
      RX_LINE_HIGH,
      RX_WAIT_START,
      RX_START,
      RX_DATA
   } rx_state_e;

endpackage

// ==== logic/uart_rx.sv ====
/*
 * receive sequencer, line resync, start detect, mid-bit sampling
 * raises rts once running
 */

`timescale 1ns/100ps

module uart_rx #(
   parameter int DIV_W = uart_pkg::DIV_W
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             soft_rst_i,
   input  logic             rx_en_i,
   input  logic             rxd_i,
   input  logic             rx_read_i,
   input  logic [DIV_W-1:0] bit_duration_i,
   output logic             rx_ready_o,
   output logic [7:0]       rx_data_o,
   output logic             rts_o
);

   import uart_pkg::*;

   rx_state_e        state_q, state_d;
   logic [DIV_W-1:0] cyclecnt_q, cyclecnt_d;
   logic [DIV_W-1:0] cnt_inc;
   logic [3:0]       bitcnt_q, bitcnt_d;
   logic [7:0]       pattern_q, pattern_d;  // shift in LSB first
   logic [7:0]       data_q, data_d;
   logic             ready_q, ready_d;
   logic             rts_q, rts_d;

   assign cnt_inc    = cyclecnt_q + 1'b1;
   assign rx_ready_o = ready_q;
   assign rx_data_o  = data_q;
   assign rts_o      = rts_q;

   always_comb begin
      state_d    = state_q;
      cyclecnt_d = cyclecnt_q;
      bitcnt_d   = bitcnt_q;
      pattern_d  = pattern_q;
      data_d     = data_q;
      ready_d    = ready_q;
      rts_d      = rts_q;
      case (state_q)
         RX_SYNC: begin
            rts_d      = 1'b1;
            ready_d    = 1'b0;
            cyclecnt_d = DIV_W'(1);
            bitcnt_d   = 4'd0;
            if (rxd_i) begin  // wait for a high line
               state_d = RX_LINE_HIGH;
            end
         end
         RX_LINE_HIGH: begin
            cyclecnt_d = cnt_inc;
            if (cyclecnt_q == bit_duration_i) begin
               state_d = rxd_i ? RX_WAIT_START : RX_SYNC;  // dropped early, resync
            end
         end
         RX_WAIT_START: begin
            cyclecnt_d = DIV_W'(1);
            if (!rxd_i) begin
               state_d = RX_START;
            end
         end
         RX_START: begin
            cyclecnt_d = cnt_inc;
            if (cyclecnt_q == (bit_duration_i >> 1)) begin  // half a bit in
               if (rxd_i) begin  // glitch, not a start bit
                  state_d = RX_SYNC;
               end else begin
                  cyclecnt_d = DIV_W'(1);
                  state_d    = RX_DATA;
               end
            end
         end
         RX_DATA: begin
            cyclecnt_d = cnt_inc;
            if (cyclecnt_q == bit_duration_i) begin
               cyclecnt_d = DIV_W'(1);
               bitcnt_d   = bitcnt_q + 4'd1;
               pattern_d  = {rxd_i, pattern_q[7:1]};
               if (bitcnt_q == 4'd8) begin  // this sample is the stop bit
                  data_d   = pattern_q;
                  ready_d  = 1'b1;
                  bitcnt_d = 4'd0;
                  state_d  = RX_WAIT_START;
               end
            end
         end
         default: state_d = RX_SYNC;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= RX_SYNC;
         cyclecnt_q <= DIV_W'(1);
         bitcnt_q   <= 4'd0;
         pattern_q  <= 8'd0;
         data_q     <= 8'd0;
         rts_q      <= 1'b0;
      end else if (soft_rst_i) begin
         state_q    <= RX_SYNC;
         cyclecnt_q <= DIV_W'(1);
         bitcnt_q   <= 4'd0;
         pattern_q  <= 8'd0;
         data_q     <= 8'd0;
         rts_q      <= 1'b0;
      end else if (rx_en_i) begin
         state_q    <= state_d;
         cyclecnt_q <= cyclecnt_d;
         bitcnt_q   <= bitcnt_d;
         pattern_q  <= pattern_d;
         data_q     <= data_d;
         rts_q      <= rts_d;
      end
   end

   // read clear wins over a new frame
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ready_q <= 1'b0;
      end else if (soft_rst_i || rx_read_i) begin
         ready_q <= 1'b0;
      end else if (rx_en_i) begin
         ready_q <= ready_d;
      end
   end

endmodule

// ==== logic/uart_sync.sv ====
/* two-flop synchronizer for the asynchronous serial inputs */

`timescale 1ns/100ps

module uart_sync #(
   parameter int WIDTH = 2
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic [WIDTH-1:0] async_i,
   output logic [WIDTH-1:0] sync_o
);

   logic [WIDTH-1:0] meta_q;
   logic [WIDTH-1:0] sync_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         meta_q <= '1;  // idle line high, cts asserted
         sync_q <= '1;
      end else begin
         meta_q <= async_i;
         sync_q <= meta_q;
      end
   end

   assign sync_o = sync_q;

endmodule

// ==== logic/uart_top.sv ====
/*
 * serial port top level, host arbiter, registers, synchronizer, tx and rx
 */

`timescale 1ns/100ps

module uart_top #(
   parameter int DIV_W  = uart_pkg::DIV_W,
   parameter int ADDR_W = uart_pkg::ADDR_W,
   parameter int DATA_W = uart_pkg::DATA_W
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              host0_req_i,
   input  logic              host0_we_i,
   input  logic [ADDR_W-1:0] host0_addr_i,
   input  logic [DATA_W-1:0] host0_wdata_i,
   output logic              host0_ack_o,
   output logic [DATA_W-1:0] host0_rdata_o,
   input  logic              host1_req_i,
   input  logic              host1_we_i,
   input  logic [ADDR_W-1:0] host1_addr_i,
   input  logic [DATA_W-1:0] host1_wdata_i,
   output logic              host1_ack_o,
   output logic [DATA_W-1:0] host1_rdata_o,
   input  logic              rxd_i,
   input  logic              cts_i,
   output logic              txd_o,
   output logic              rts_o
);

   logic              bus_valid, bus_we;
   logic [ADDR_W-1:0] bus_addr;
   logic [DATA_W-1:0] bus_wdata, bus_rdata;
   logic [DIV_W-1:0]  bit_duration;
   logic              tx_en, rx_en, soft_rst;
   logic              tx_write, rx_read;
   logic [7:0]        tx_data, rx_data;
   logic              tx_ready, rx_ready;
   logic [1:0]        line_sync;  // {cts, rxd}

   uart_bus_arb #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_arb (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .req0_i(host0_req_i), .we0_i(host0_we_i), .addr0_i(host0_addr_i),
      .wdata0_i(host0_wdata_i), .ack0_o(host0_ack_o), .rdata0_o(host0_rdata_o),
      .req1_i(host1_req_i), .we1_i(host1_we_i), .addr1_i(host1_addr_i),
      .wdata1_i(host1_wdata_i), .ack1_o(host1_ack_o), .rdata1_o(host1_rdata_o),
      .bus_valid_o(bus_valid), .bus_we_o(bus_we), .bus_addr_o(bus_addr),
      .bus_wdata_o(bus_wdata), .bus_rdata_i(bus_rdata)
   );

   uart_csr #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .DIV_W(DIV_W)) i_csr (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .bus_valid_i(bus_valid), .bus_we_i(bus_we), .bus_addr_i(bus_addr),
      .bus_wdata_i(bus_wdata), .bus_rdata_o(bus_rdata),
      .bit_duration_o(bit_duration), .tx_en_o(tx_en), .rx_en_o(rx_en),
      .soft_rst_o(soft_rst), .tx_write_o(tx_write), .tx_data_o(tx_data),
      .rx_read_o(rx_read), .tx_ready_i(tx_ready), .rx_ready_i(rx_ready),
      .rx_data_i(rx_data)
   );

   uart_sync #(.WIDTH(2)) i_sync (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .async_i({cts_i, rxd_i}), .sync_o(line_sync)
   );

   uart_tx #(.DIV_W(DIV_W)) i_tx (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .soft_rst_i(soft_rst),
      .tx_en_i(tx_en), .cts_i(line_sync[1]), .tx_write_i(tx_write),
      .tx_data_i(tx_data), .bit_duration_i(bit_duration),
      .tx_ready_o(tx_ready), .txd_o(txd_o)
   );

   uart_rx #(.DIV_W(DIV_W)) i_rx (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .soft_rst_i(soft_rst),
      .rx_en_i(rx_en), .rxd_i(line_sync[0]), .rx_read_i(rx_read),
      .bit_duration_i(bit_duration), .rx_ready_o(rx_ready),
      .rx_data_o(rx_data), .rts_o(rts_o)
   );

endmodule

// ==== logic/uart_tx.sv ====
/*
 * transmit sequencer, start + 8 data + stop, LSB first
 * steps only while enabled and cleared to send
 */

`timescale 1ns/100ps

module uart_tx #(
   parameter int DIV_W = uart_pkg::DIV_W
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             soft_rst_i,
   input  logic             tx_en_i,
   input  logic             cts_i,
   input  logic             tx_write_i,
   input  logic [7:0]       tx_data_i,
   input  logic [DIV_W-1:0] bit_duration_i,
   output logic             tx_ready_o,
   output logic             txd_o
);

   import uart_pkg::*;

   tx_state_e        state_q, state_d;
   logic [9:0]       pattern_q, pattern_d;  // {stop, data, start}
   logic [3:0]       bitcnt_q, bitcnt_d;
   logic [DIV_W-1:0] cyclecnt_q, cyclecnt_d;
   logic             ready_q, ready_d;
   logic             pend_q;                // write seen, frame not yet loaded
   logic [7:0]       data_q;
   logic             step;
   logic             go;

   assign step       = tx_en_i & cts_i;
   assign go         = tx_write_i | pend_q;
   assign txd_o      = pattern_q[0];
   assign tx_ready_o = ready_q & ~pend_q;  // busy as soon as a byte is pending

   always_ff @(posedge clk_i) begin
      if (tx_write_i) begin
         data_q <= tx_data_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pend_q <= 1'b0;
      end else if (soft_rst_i) begin
         pend_q <= 1'b0;
      end else if (tx_write_i) begin
         pend_q <= 1'b1;
      end else if (step && state_q == TX_LOAD) begin
         pend_q <= 1'b0;
      end
   end

   always_comb begin
      state_d    = state_q;
      pattern_d  = pattern_q;
      bitcnt_d   = bitcnt_q;
      cyclecnt_d = cyclecnt_q;
      ready_d    = ready_q;
      case (state_q)
         TX_IDLE: begin
            ready_d    = 1'b1;
            bitcnt_d   = 4'd0;
            cyclecnt_d = DIV_W'(1);
            pattern_d  = '1;  // line idles high
            if (go) begin
               state_d = TX_LOAD;
               ready_d = 1'b0;
            end
         end
         TX_LOAD: begin
            pattern_d = {1'b1, data_q, 1'b0};
            state_d   = TX_SEND;
         end
         TX_SEND: begin
            cyclecnt_d = cyclecnt_q + 1'b1;
            if (cyclecnt_q == bit_duration_i) begin
               if (bitcnt_q == 4'd9) begin  // stop bit done
                  state_d = TX_IDLE;
               end else begin
                  pattern_d  = {1'b0, pattern_q[9:1]};
                  bitcnt_d   = bitcnt_q + 4'd1;
                  cyclecnt_d = DIV_W'(1);
               end
            end
         end
         default: state_d = TX_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= TX_IDLE;
         pattern_q  <= '1;
         bitcnt_q   <= 4'd0;
         cyclecnt_q <= '0;
         ready_q    <= 1'b0;
      end else if (soft_rst_i) begin
         state_q    <= TX_IDLE;
         pattern_q  <= '1;
         bitcnt_q   <= 4'd0;
         cyclecnt_q <= '0;
         ready_q    <= 1'b0;
      end else if (step) begin  // frozen otherwise
         state_q    <= state_d;
         pattern_q  <= pattern_d;
         bitcnt_q   <= bitcnt_d;
         cyclecnt_q <= cyclecnt_d;
         ready_q    <= ready_d;
      end
   end

endmodule

// ==== vlog.f ====
logic/uart_pkg.sv
logic/uart_sync.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_bus_arb.sv
logic/uart_csr.sv
logic/uart_top.sv
bench/uart_checker.sv
bench/uart_tb.sv
